// ==== design/cache_pkg.sv ====
package cache_pkg;

    // address fields from the top are tag, set, word and byte.
    localparam int addr_width  = 32;
    localparam int data_width  = 32;
    localparam int num_sets    = 4;
    localparam int set_bits    = $clog2(num_sets);
    localparam int num_ways    = 4;
    localparam int way_bits    = $clog2(num_ways);
    localparam int line_words  = 16;
    localparam int word_bits   = $clog2(line_words);
    localparam int byte_bits   = $clog2(data_width / 8);
    localparam int offset_bits = word_bits + byte_bits;
    localparam int tag_bits    = addr_width - set_bits - offset_bits;  // 24 bits.

    typedef struct packed {
        logic                    write;
        logic [addr_width-1:0]   addr;
        logic [data_width/8-1:0] wstrb;
        logic [data_width-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                  ar_valid;
        logic [addr_width-1:0] ar_addr;
    } mem_rd_t;

    typedef struct packed {
        logic                  r_valid;
        logic                  r_last;
        logic [data_width-1:0] r_data;
    } mem_rdata_t;

    typedef struct packed {
        logic                  aw_valid;
        logic [addr_width-1:0] aw_addr;
        logic                  w_valid;
        logic                  w_last;
        logic [data_width-1:0] w_data;
    } mem_wr_t;

    typedef struct packed {
        logic                hit;
        logic [way_bits-1:0] way;           // hit way, or victim way on a miss.
        logic                victim_dirty;
    } lookup_t;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_evict_addr,
        st_evict_data,
        st_evict_resp,
        st_refill_addr,
        st_refill_data,
        st_install
    } ctrl_state_t;

endpackage

// ==== design/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [cache_pkg::addr_width-1:0] addr,
    input  logic                             install,
    input  logic                             mark_dirty,
    output cache_pkg::lookup_t               lookup,
    output logic [cache_pkg::tag_bits-1:0]   victim_tag
);

    logic [cache_pkg::tag_bits-1:0] tags [cache_pkg::num_sets][cache_pkg::num_ways];
    logic [cache_pkg::num_ways-1:0] valid [cache_pkg::num_sets];
    logic [cache_pkg::num_ways-1:0] dirty [cache_pkg::num_sets];
    logic [cache_pkg::way_bits-1:0] rr_ptr [cache_pkg::num_sets];

    logic [cache_pkg::set_bits-1:0] set;
    logic [cache_pkg::tag_bits-1:0] tag;
    logic [cache_pkg::num_ways-1:0] hit_vec;
    logic [cache_pkg::way_bits-1:0] hit_way;
    logic [cache_pkg::way_bits-1:0] victim_way;

    assign set = addr[cache_pkg::offset_bits +: cache_pkg::set_bits];
    assign tag = addr[cache_pkg::addr_width-1 -: cache_pkg::tag_bits];
    assign victim_way = rr_ptr[set];  // round-robin choice for this set.
    assign victim_tag = tags[set][victim_way];

    // compare against every valid way of the indexed set.
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            hit_vec[w] = valid[set][w] && (tags[set][w] == tag);
            if (hit_vec[w]) begin
                hit_way = w[cache_pkg::way_bits-1:0];
            end
        end
    end

    always_comb begin
        lookup.hit          = |hit_vec;
        lookup.way          = (|hit_vec) ? hit_way : victim_way;
        lookup.victim_dirty = dirty[set][victim_way];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_pkg::num_sets; s++) begin
                valid[s]  <= '0;
                dirty[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (install) begin
            valid[set][victim_way] <= 1'b1;
            dirty[set][victim_way] <= 1'b0;  // fresh line matches memory.
            rr_ptr[set]            <= victim_way + 1'b1;
        end else if (mark_dirty && (|hit_vec)) begin
            dirty[set][hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tags[set][victim_way] <= tag;
        end
    end

    // a tag lives in at most one way of its set.
    hit_unique: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec));

endmodule

// ==== design/cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store (
    input  logic                               clk,
    input  logic [cache_pkg::set_bits-1:0]     set,
    input  logic [cache_pkg::way_bits-1:0]     way,
    input  logic [cache_pkg::word_bits-1:0]    word,
    input  logic [cache_pkg::data_width/8-1:0] wstrb,
    input  logic [cache_pkg::data_width-1:0]   wdata,
    input  logic                               we,
    output logic [cache_pkg::data_width-1:0]   rdata
);

    // one word per set, way and line offset.
    logic [cache_pkg::data_width-1:0] mem
        [cache_pkg::num_sets][cache_pkg::num_ways][cache_pkg::line_words];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < cache_pkg::data_width / 8; b++) begin
                if (wstrb[b]) begin
                    mem[set][way][word][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // combinational read and the write shows up after the edge.
    assign rdata = mem[set][way][word];

endmodule

// ==== design/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  cache_pkg::cpu_req_t                req,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [cache_pkg::data_width-1:0]   resp_rdata,
    output logic [cache_pkg::addr_width-1:0]   addr,
    input  cache_pkg::lookup_t                 lookup,
    input  logic [cache_pkg::tag_bits-1:0]     victim_tag,
    output logic                               install,
    output logic                               mark_dirty,
    output logic [cache_pkg::set_bits-1:0]     set,
    output logic [cache_pkg::way_bits-1:0]     way,
    output logic [cache_pkg::word_bits-1:0]    word,
    output logic [cache_pkg::data_width/8-1:0] wstrb,
    output logic [cache_pkg::data_width-1:0]   wdata,
    output logic                               we,
    input  logic [cache_pkg::data_width-1:0]   rdata,
    output cache_pkg::mem_rd_t                 mem_rd,
    input  cache_pkg::mem_rdata_t              mem_rdata,
    input  logic                               ar_ready,
    output cache_pkg::mem_wr_t                 mem_wr,
    input  logic                               aw_ready,
    input  logic                               w_ready,
    input  logic                               b_valid
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::cpu_req_t req_q;
    logic [cache_pkg::word_bits-1:0] beat;
    logic hit_access;
    logic refill;
    logic burst;

    assign hit_access = (state == cache_pkg::st_lookup) && lookup.hit;
    assign refill     = state == cache_pkg::st_refill_data;
    assign burst      = refill || (state == cache_pkg::st_evict_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::st_idle;
            beat  <= '0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (req_valid) state <= cache_pkg::st_lookup;
                end
                cache_pkg::st_lookup: begin
                    if (lookup.hit) begin
                        state <= cache_pkg::st_respond;
                    end else if (lookup.victim_dirty) begin
                        state <= cache_pkg::st_evict_addr;
                    end else begin
                        state <= cache_pkg::st_refill_addr;
                    end
                end
                cache_pkg::st_respond: state <= cache_pkg::st_idle;
                cache_pkg::st_evict_addr: begin
                    if (aw_ready) begin
                        state <= cache_pkg::st_evict_data;
                        beat  <= '0;
                    end
                end
                cache_pkg::st_evict_data: begin
                    if (w_ready) begin
                        beat <= beat + 1'b1;
                        if (beat == '1) state <= cache_pkg::st_evict_resp;
                    end
                end
                cache_pkg::st_evict_resp: begin
                    if (b_valid) state <= cache_pkg::st_refill_addr;
                end
                cache_pkg::st_refill_addr: begin
                    if (ar_ready) begin
                        state <= cache_pkg::st_refill_data;
                        beat  <= '0;
                    end
                end
                cache_pkg::st_refill_data: begin
                    if (mem_rdata.r_valid) begin
                        beat <= beat + 1'b1;
                        if (mem_rdata.r_last) state <= cache_pkg::st_install;
                    end
                end
                // retry the lookup so that it now hits.
                cache_pkg::st_install: state <= cache_pkg::st_lookup;
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (hit_access && !req_q.write) resp_rdata <= rdata;
    end

    assign req_ready  = state == cache_pkg::st_idle;
    assign resp_valid = state == cache_pkg::st_respond;
    assign addr       = req_q.addr;
    assign install    = state == cache_pkg::st_install;
    assign mark_dirty = hit_access && req_q.write;

    // data store port shared by hits and both bursts.
    assign set   = req_q.addr[cache_pkg::offset_bits +: cache_pkg::set_bits];
    assign way   = lookup.way;
    assign word  = burst ? beat : req_q.addr[cache_pkg::byte_bits +: cache_pkg::word_bits];
    assign wstrb = refill ? '1 : req_q.wstrb;
    assign wdata = refill ? mem_rdata.r_data : req_q.wdata;
    assign we    = mark_dirty || (refill && mem_rdata.r_valid);

    always_comb begin
        mem_rd.ar_valid = state == cache_pkg::st_refill_addr;
        mem_rd.ar_addr  = {req_q.addr[cache_pkg::addr_width-1:cache_pkg::offset_bits],
                           {cache_pkg::offset_bits{1'b0}}};
    end

    always_comb begin
        mem_wr.aw_valid = state == cache_pkg::st_evict_addr;
        mem_wr.aw_addr  = {victim_tag, set, {cache_pkg::offset_bits{1'b0}}};  // victim line.
        mem_wr.w_valid  = state == cache_pkg::st_evict_data;
        mem_wr.w_last   = (state == cache_pkg::st_evict_data) && (beat == '1);
        mem_wr.w_data   = rdata;
    end

    // a stalled write beat keeps its data and last flag.
    w_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr.w_valid && !w_ready |=>
            mem_wr.w_valid && $stable({mem_wr.w_last, mem_wr.w_data}));

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr.aw_valid && !aw_ready |=> mem_wr.aw_valid && $stable(mem_wr.aw_addr));

endmodule

// ==== design/data_cache.sv ====
`timescale 1ns/1ps

module data_cache (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             req_valid,
    input  cache_pkg::cpu_req_t              req,
    output logic                             req_ready,
    output logic                             resp_valid,
    output logic [cache_pkg::data_width-1:0] resp_rdata,
    output cache_pkg::mem_rd_t               mem_rd,
    input  logic                             ar_ready,
    input  cache_pkg::mem_rdata_t            mem_rdata,
    output cache_pkg::mem_wr_t               mem_wr,
    input  logic                             aw_ready,
    input  logic                             w_ready,
    input  logic                             b_valid
);

    logic [cache_pkg::addr_width-1:0]   addr;
    logic                               install;
    logic                               mark_dirty;
    cache_pkg::lookup_t                 lookup;
    logic [cache_pkg::tag_bits-1:0]     victim_tag;
    logic [cache_pkg::set_bits-1:0]     set;
    logic [cache_pkg::way_bits-1:0]     way;
    logic [cache_pkg::word_bits-1:0]    word;
    logic [cache_pkg::data_width/8-1:0] wstrb;
    logic [cache_pkg::data_width-1:0]   wdata;
    logic                               we;
    logic [cache_pkg::data_width-1:0]   rdata;

    cache_controller u_controller (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .addr(addr),
        .lookup(lookup),
        .victim_tag(victim_tag),
        .install(install),
        .mark_dirty(mark_dirty),
        .set(set),
        .way(way),
        .word(word),
        .wstrb(wstrb),
        .wdata(wdata),
        .we(we),
        .rdata(rdata),
        .mem_rd(mem_rd),
        .mem_rdata(mem_rdata),
        .ar_ready(ar_ready),
        .mem_wr(mem_wr),
        .aw_ready(aw_ready),
        .w_ready(w_ready),
        .b_valid(b_valid)
    );

    cache_tag_store u_tag_store (
        .clk(clk),
        .reset(reset),
        .addr(addr),
        .install(install),
        .mark_dirty(mark_dirty),
        .lookup(lookup),
        .victim_tag(victim_tag)
    );

    cache_data_store u_data_store (
        .clk(clk),
        .set(set),
        .way(way),
        .word(word),
        .wstrb(wstrb),
        .wdata(wdata),
        .we(we),
        .rdata(rdata)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    // reset is released on the tenth rising edge.
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== testbench/tb_data_cache.sv ====
`timescale 1ns/1ps

module tb_data_cache;

    typedef struct packed {
        logic        write;
        logic        hit;       // response expected 2 cycles after acceptance.
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic [15:0] line_no;
    } golden_op_t;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    cache_pkg::cpu_req_t   req;
    logic                  req_ready;
    logic                  resp_valid;
    logic [31:0]           resp_rdata;
    cache_pkg::mem_rd_t    mem_rd;
    logic                  ar_ready;
    cache_pkg::mem_rdata_t mem_rdata;
    cache_pkg::mem_wr_t    mem_wr;
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;

    golden_op_t  ops[$];
    logic [31:0] mem_words [4096];  // 16 KB of backing memory.
    logic [31:0] lcg_state = 32'd55;
    int          cycle_count;
    int          cycle_limit;
    int          wr_bursts;
    logic        rd_active;
    int          rd_beat;
    int          rd_base;
    logic        wr_active;
    int          wr_beat;
    int          wr_base;
    logic        ar_wait;
    logic        aw_wait;

    tb_clock_gen clock_gen (
        .clk(clk),
        .reset(reset)
    );

    data_cache dut (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .mem_rd(mem_rd),
        .ar_ready(ar_ready),
        .mem_rdata(mem_rdata),
        .mem_wr(mem_wr),
        .aw_ready(aw_ready),
        .w_ready(w_ready),
        .b_valid(b_valid)
    );

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with_error($sformatf("MISMATCH %s expected 0x%h actual 0x%h",
                                  name, expected, actual));
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic load_golden();
        int fd;
        int line_no;
        int fields;
        string line;
        string kind;
        logic [31:0] a;
        logic [3:0] s;
        logic [31:0] d;
        logic [31:0] e;
        golden_op_t op;
        fd = $fopen("testbench/data_cache_golden.txt", "r");
        assert (fd != 0) else stop_with_error("cannot open testbench/data_cache_golden.txt");
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;  // comments and blank lines.
            fields = $sscanf(line, "%s %h %h %h %h", kind, a, s, d, e);
            assert (fields == 5) else
                stop_with_error($sformatf("golden line %0d has %0d fields", line_no, fields));
            assert (kind == "rd" || kind == "wr" || kind == "rd_hit" || kind == "wr_hit") else
                stop_with_error($sformatf("golden line %0d has unknown kind %s", line_no, kind));
            op.write    = (kind == "wr") || (kind == "wr_hit");
            op.hit      = (kind == "rd_hit") || (kind == "wr_hit");
            op.addr     = a;
            op.wstrb    = s;
            op.wdata    = d;
            op.expected = e;
            op.line_no  = line_no[15:0];
            ops.push_back(op);
        end
        $fclose(fd);
        assert (ops.size() > 0) else stop_with_error("golden file holds no operations");
    endtask

    task automatic run_request(input golden_op_t op);
        string name;
        int latency;
        logic [31:0] got;
        cache_pkg::cpu_req_t r;
        name    = $sformatf("golden line %0d", op.line_no);
        r.write = op.write;
        r.addr  = op.addr;
        r.wstrb = op.wstrb;
        r.wdata = op.wdata;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);  // acceptance edge.
        req_valid <= 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!resp_valid);
        got = resp_rdata;
        if (op.hit) begin
            assert (latency == 2) else report_mismatch({name, " hit latency"}, 2, latency);
        end else begin
            assert (latency > 2) else
                stop_with_error($sformatf("%s should miss but responded after %0d cycles",
                                          name, latency));
        end
        if (!op.write) begin
            assert (got === op.expected) else report_mismatch(name, op.expected, got);
        end
    endtask

    // burst memory with random ready back-pressure.
    always @(posedge clk) begin : memory_model
        logic rd_on;
        int rd_next;
        int rd_base_next;
        logic [31:0] rnd;
        if (reset) begin
            ar_ready  <= 1'b0;
            aw_ready  <= 1'b0;
            w_ready   <= 1'b0;
            b_valid   <= 1'b0;
            mem_rdata <= '0;
            rd_active <= 1'b0;
            rd_beat   <= 0;
            wr_active <= 1'b0;
            wr_beat   <= 0;
            ar_wait   <= 1'b0;
            aw_wait   <= 1'b0;
        end else begin
            rnd = next_random();
            assert (!ar_wait || mem_rd.ar_valid) else
                stop_with_error("ar_valid dropped before ar_ready");
            assert (!aw_wait || mem_wr.aw_valid) else
                stop_with_error("aw_valid dropped before aw_ready");
            ar_wait <= mem_rd.ar_valid && !ar_ready;
            aw_wait <= mem_wr.aw_valid && !aw_ready;

            rd_on        = rd_active;
            rd_next      = mem_rdata.r_valid ? rd_beat + 1 : rd_beat;  // every beat is taken.
            rd_base_next = rd_base;
            if (rd_next == 16) rd_on = 1'b0;
            if (mem_rd.ar_valid && ar_ready) begin
                assert (mem_rd.ar_addr[5:0] == 0 && mem_rd.ar_addr[31:14] == 0) else
                    stop_with_error($sformatf("read burst address %h is not a modelled line",
                                              mem_rd.ar_addr));
                rd_on        = 1'b1;
                rd_next      = 0;
                rd_base_next = mem_rd.ar_addr[13:2];
            end
            rd_active <= rd_on;
            rd_beat   <= rd_next;
            rd_base   <= rd_base_next;
            if (rd_on && rnd[21:20] != 2'b00) begin
                mem_rdata.r_valid <= 1'b1;
                mem_rdata.r_last  <= rd_next == 15;
                mem_rdata.r_data  <= mem_words[rd_base_next + rd_next];
            end else begin
                mem_rdata <= '0;
            end

            b_valid <= 1'b0;
            if (mem_wr.aw_valid && aw_ready) begin
                assert (mem_wr.aw_addr[5:0] == 0 && mem_wr.aw_addr[31:14] == 0) else
                    stop_with_error($sformatf("write burst address %h is not a modelled line",
                                              mem_wr.aw_addr));
                wr_active <= 1'b1;
                wr_base   <= mem_wr.aw_addr[13:2];
                wr_beat   <= 0;
            end
            if (mem_wr.w_valid && w_ready) begin
                assert (wr_active) else
                    stop_with_error("write data arrived before its burst address");
                assert (mem_wr.w_last == (wr_beat == 15)) else
                    report_mismatch($sformatf("w_last on write beat %0d", wr_beat + 1),
                                    wr_beat == 15, mem_wr.w_last);
                mem_words[wr_base + wr_beat] = mem_wr.w_data;
                wr_beat <= wr_beat + 1;
                if (wr_beat == 15) begin
                    wr_active <= 1'b0;
                    b_valid   <= 1'b1;  // single response pulse after the last beat.
                    wr_bursts <= wr_bursts + 1;
                end
            end
            ar_ready <= rnd[24];
            aw_ready <= rnd[25];
            w_ready  <= rnd[27:26] != 2'b00;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_with_error($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
        end
    end

    initial begin
        req_valid = 1'b0;
        req       = '0;
        mem_rdata = '0;
        ar_ready  = 1'b0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        wr_bursts = 0;
        for (int i = 0; i < 4096; i++) begin
            mem_words[i] = i ^ 32'hA5A5_0000;  // word address xor fill.
        end
        load_golden();
        cycle_limit = 400 * ops.size() + 20;
        @(negedge clk);
        while (reset) @(negedge clk);
        assert (req_ready && !resp_valid) else
            stop_with_error("wrong request handshake after reset");
        assert (!mem_rd.ar_valid && !mem_wr.aw_valid && !mem_wr.w_valid) else
            stop_with_error("memory request active after reset");
        foreach (ops[i]) begin
            run_request(ops[i]);
        end
        if (wr_bursts > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_with_error("no dirty victim was written back to memory");
        end
    end

endmodule

// ==== testbench/data_cache_golden.txt ====
# kind address strobe write_data expected_read_data, all hex; expected is ignored for writes
# rd and wr must miss, rd_hit and wr_hit must respond 2 cycles after acceptance
rd     00000100 0 00000000 a5a50040
rd_hit 00000108 0 00000000 a5a50042
rd_hit 0000013c 0 00000000 a5a5004f
wr_hit 00000104 3 1234abcd 00000000
rd_hit 00000104 0 00000000 a5a5abcd
wr_hit 00000104 c 77660000 00000000
rd_hit 00000104 0 00000000 7766abcd
wr     00000040 f deadbeef 00000000
rd_hit 00000040 0 00000000 deadbeef
wr_hit 0000007c 9 11223344 00000000
rd_hit 0000007c 0 00000000 11a50044
rd     00000140 0 00000000 a5a50050
rd     00000240 0 00000000 a5a50090
rd     00000340 0 00000000 a5a500d0
rd     00000440 0 00000000 a5a50110
rd     00000040 0 00000000 deadbeef
rd_hit 0000007c 0 00000000 11a50044
rd_hit 00000044 0 00000000 a5a50011
wr     00000284 6 00cafe00 00000000
rd_hit 00000284 0 00000000 a5cafea1
wr     00000388 f 0badf00d 00000000
rd     00000480 0 00000000 a5a50120
rd     00000580 0 00000000 a5a50160
rd     00000680 0 00000000 a5a501a0
rd     00000780 0 00000000 a5a501e0
rd     00000284 0 00000000 a5cafea1
rd     00000388 0 00000000 0badf00d

// ==== compile.f ====
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_controller.sv
design/data_cache.sv
testbench/tb_clock_gen.sv
testbench/tb_data_cache.sv

// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - design/cache_pkg.sv
  - design/cache_tag_store.sv
  - design/cache_data_store.sv
  - design/cache_controller.sv
  - design/data_cache.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_data_cache.sv
